/* dv/soc_properties.sv */
// Bus protocol assertions
`timescale 1ns/1ns
`default_nettype none

module soc_properties (
  input logic clk,
  input logic rst_n_i,
  input logic stb_i,
  input logic cyc_i,
  input logic ack_i,
  input logic main_stb_i,
  input logic video_stb_i,
  input logic inta_done_i,
  input logic led_wr_i,
  input logic main_ack_i,
  input logic video_ack_i
);

  // Every ack answers an open request
  ack_needs_req: assert property (
    @(posedge clk) disable iff (!rst_n_i)
    ack_i |-> (stb_i && cyc_i)
  ) else $error("ack seen without stb and cyc");

  // RAM acks are single pulses
  main_ack_pulse: assert property (
    @(posedge clk) disable iff (!rst_n_i)
    main_ack_i |=> !main_ack_i
  ) else $error("main RAM ack held longer than one cycle");

  video_ack_pulse: assert property (
    @(posedge clk) disable iff (!rst_n_i)
    video_ack_i |=> !video_ack_i
  ) else $error("video RAM ack held longer than one cycle");

  // At most one slave selected or still acking
  strobes_onehot: assert property (
    @(posedge clk) disable iff (!rst_n_i)
    $onehot0({main_stb_i | main_ack_i, video_stb_i | video_ack_i, inta_done_i, led_wr_i})
  ) else $error("more than one slave strobe or ack active");

endmodule

bind bus_fabric soc_properties i_soc_properties (
  .clk         (clk),
  .rst_n_i     (rst_n_i),
  .stb_i       (stb_i),
  .cyc_i       (cyc_i),
  .ack_i       (ack_o),
  .main_stb_i  (main_stb_o),
  .video_stb_i (video_stb_o),
  .inta_done_i (inta_done_o),
  .led_wr_i    (led_wr),
  .main_ack_i  (main_ack_i),
  .video_ack_i (video_ack_i)
);

`default_nettype wire

/* dv/soc_tb.sv */
// System bus testbench
`timescale 1ns/1ns
`default_nettype none

module soc_tb;

  import bus_pkg::*;

  localparam int unsigned ACK_TIMEOUT  = 16;
  localparam int unsigned IRQ_TIMEOUT  = 8;
  localparam int unsigned TIMER_MARGIN = 16;
  localparam int unsigned NUM_WORDS    = 8;

  logic  clk;
  logic  rst_n_i;
  adr_t  adr_i;
  word_t dat_i;
  logic  we_i;
  logic  tga_i;
  sel_t  sel_i;
  logic  stb_i;
  logic  cyc_i;
  logic  inta_i;
  word_t dat_o;
  logic  ack_o;
  logic  ext_irq_i;
  logic  intr_o;
  word_t led_o;

  int unsigned check_cnt;
  int unsigned error_cnt;
  int unsigned timeout_cnt;

  soc_top i_soc_top (
    .clk       (clk),
    .rst_n_i   (rst_n_i),
    .adr_i     (adr_i),
    .dat_i     (dat_i),
    .we_i      (we_i),
    .tga_i     (tga_i),
    .sel_i     (sel_i),
    .stb_i     (stb_i),
    .cyc_i     (cyc_i),
    .inta_i    (inta_i),
    .dat_o     (dat_o),
    .ack_o     (ack_o),
    .ext_irq_i (ext_irq_i),
    .intr_o    (intr_o),
    .led_o     (led_o)
  );

  initial begin
    clk = 1'b0;
    forever #4 clk = ~clk;
  end

  // Hard stop if the run ever stalls
  initial begin
    #200000;
    $display("Watchdog expired before the tests finished");
    $display("*** FAILED ***");
    $finish;
  end

  task automatic check_word(input string name, input word_t exp, input word_t act);
    check_cnt++;
    if (act !== exp) begin
      error_cnt++;
      $display("CHECK FAILED %s: expected %h, actual %h", name, exp, act);
    end
  endtask

  task automatic check_bit(input string name, input logic exp, input logic act);
    check_cnt++;
    if (act !== exp) begin
      error_cnt++;
      $display("CHECK FAILED %s: expected %b, actual %b", name, exp, act);
    end
  endtask

  // One Wishbone cycle, data is taken at the clock edge that sees ack
  task automatic run_bus_cycle(input logic [19:0] addr, input logic io, input logic we,
                               input logic inta, input sel_t sel, input word_t wdata,
                               output word_t rdata);
    int unsigned waited;
    logic        got_ack;
    waited  = 0;
    got_ack = 1'b0;
    rdata   = '0;
    @(negedge clk);
    adr_i  = addr[19:1];
    tga_i  = io;
    we_i   = we;
    inta_i = inta;
    sel_i  = sel;
    dat_i  = wdata;
    stb_i  = 1'b1;
    cyc_i  = 1'b1;
    while (!got_ack && waited < ACK_TIMEOUT) begin
      @(posedge clk);
      if (ack_o) begin
        rdata   = dat_o;
        got_ack = 1'b1;
      end
      waited++;
    end
    @(negedge clk);
    stb_i  = 1'b0;
    cyc_i  = 1'b0;
    we_i   = 1'b0;
    inta_i = 1'b0;
    if (!got_ack) begin
      timeout_cnt++;
      $display("No ack for the bus cycle at address %h (io %b, we %b, inta %b)",
               addr, io, we, inta);
    end
  endtask

  task automatic bus_write(input logic [19:0] addr, input logic io, input sel_t sel,
                           input word_t data);
    word_t unused_rdata;
    run_bus_cycle(addr, io, 1'b1, 1'b0, sel, data, unused_rdata);
  endtask

  task automatic bus_read(input logic [19:0] addr, input logic io, output word_t data);
    run_bus_cycle(addr, io, 1'b0, 1'b0, 2'b11, '0, data);
  endtask

  task automatic int_ack(output word_t vec);
    run_bus_cycle(20'h00000, 1'b0, 1'b0, 1'b1, 2'b11, '0, vec);
  endtask

  // Called on a falling edge
  task automatic wait_for_intr(input string name, input int unsigned limit);
    int unsigned waited;
    waited = 0;
    while (!intr_o && waited < limit) begin
      @(negedge clk);
      waited++;
    end
    if (!intr_o) begin
      timeout_cnt++;
      $display("intr never rose while waiting in %s", name);
    end
  endtask

  task automatic pulse_ext_irq();
    @(negedge clk);
    ext_irq_i = 1'b1;
    @(negedge clk);
    ext_irq_i = 1'b0;
  endtask

  task automatic test_main_ram();
    logic [19:0] addr [NUM_WORDS];
    word_t       expect_mem [NUM_WORDS];
    word_t       rdata;
    word_t       lane_dat;
    for (int i = 0; i < NUM_WORDS; i++) begin
      addr[i]       = 20'h00400 + 20'(i) * 20'h00132;
      expect_mem[i] = word_t'($urandom);
      bus_write(addr[i], 1'b0, 2'b11, expect_mem[i]);
    end
    for (int i = 0; i < NUM_WORDS; i++) begin
      bus_read(addr[i], 1'b0, rdata);
      check_word("main_ram word", expect_mem[i], rdata);
    end
    // Low lane only, then high lane only
    lane_dat = word_t'($urandom);
    bus_write(addr[0], 1'b0, 2'b01, lane_dat);
    expect_mem[0] = {expect_mem[0][15:8], lane_dat[7:0]};
    bus_read(addr[0], 1'b0, rdata);
    check_word("main_ram low byte", expect_mem[0], rdata);
    lane_dat = word_t'($urandom);
    bus_write(addr[0], 1'b0, 2'b10, lane_dat);
    expect_mem[0] = {lane_dat[15:8], expect_mem[0][7:0]};
    bus_read(addr[0], 1'b0, rdata);
    check_word("main_ram high byte", expect_mem[0], rdata);
  endtask

  task automatic test_video_page();
    logic [19:0] off;
    word_t       main_dat;
    word_t       video_dat;
    word_t       rdata;
    off       = 20'h002A4;
    main_dat  = word_t'($urandom);
    video_dat = word_t'($urandom);
    bus_write(20'h00000 + off, 1'b0, 2'b11, main_dat);
    bus_write(20'hB8000 + off, 1'b0, 2'b11, video_dat);
    bus_read(20'h00000 + off, 1'b0, rdata);
    check_word("main after video write", main_dat, rdata);
    bus_read(20'hB8000 + off, 1'b0, rdata);
    check_word("video readback", video_dat, rdata);
    // Reverse order
    main_dat  = word_t'($urandom);
    video_dat = word_t'($urandom);
    bus_write(20'hB8000 + off, 1'b0, 2'b11, video_dat);
    bus_write(20'h00000 + off, 1'b0, 2'b11, main_dat);
    bus_read(20'hB8000 + off, 1'b0, rdata);
    check_word("video after main write", video_dat, rdata);
    bus_read(20'h00000 + off, 1'b0, rdata);
    check_word("main readback", main_dat, rdata);
    // Main RAM decodes only its low word address bits
    main_dat = word_t'($urandom);
    bus_write(20'h40000 + off, 1'b0, 2'b11, main_dat);
    bus_read(20'h00000 + off, 1'b0, rdata);
    check_word("main alias", main_dat, rdata);
  endtask

  task automatic test_led_io();
    word_t led_dat;
    word_t lane_dat;
    word_t rdata;
    led_dat = word_t'($urandom);
    bus_write(20'h0F100, 1'b1, 2'b11, led_dat);
    check_word("led output", led_dat, led_o);
    bus_read(20'h0F100, 1'b1, rdata);
    check_word("led readback", led_dat, rdata);
    lane_dat = word_t'($urandom);
    bus_write(20'h0F102, 1'b1, 2'b01, lane_dat);
    led_dat = {led_dat[15:8], lane_dat[7:0]};
    check_word("led low byte", led_dat, led_o);
    // Writes outside the LED page go nowhere
    bus_write(20'h0F200, 1'b1, 2'b11, ~led_dat);
    check_word("led after unmapped write", led_dat, led_o);
    bus_read(20'h00060, 1'b1, rdata);
    check_word("unmapped io read", UNMAPPED_IO_DATA, rdata);
  endtask

  task automatic test_timer_irq();
    word_t vec;
    // A request left over from the memory tests can only be the timer
    if (intr_o) begin
      int_ack(vec);
      check_word("stale timer vector", IRQ_VECTOR_BASE, vec);
    end
    wait_for_intr("timer irq", TIMER_PERIOD + TIMER_MARGIN);
    check_bit("timer intr", 1'b1, intr_o);
    int_ack(vec);
    check_word("timer vector", IRQ_VECTOR_BASE, vec);
    check_bit("intr after timer ack", 1'b0, intr_o);
  endtask

  task automatic test_ext_irq();
    word_t vec;
    pulse_ext_irq();
    wait_for_intr("ext irq", IRQ_TIMEOUT);
    check_bit("ext intr", 1'b1, intr_o);
    int_ack(vec);
    check_word("ext vector", IRQ_VECTOR_BASE + 16'd1, vec);
    check_bit("intr after ext ack", 1'b0, intr_o);
  endtask

  task automatic test_both_irqs();
    word_t vec;
    // Line the external pulse up right after a timer request
    wait_for_intr("both irqs", TIMER_PERIOD + TIMER_MARGIN);
    pulse_ext_irq();
    int_ack(vec);
    check_word("first of two vectors", IRQ_VECTOR_BASE, vec);
    check_bit("intr between acks", 1'b1, intr_o);
    int_ack(vec);
    check_word("second of two vectors", IRQ_VECTOR_BASE + 16'd1, vec);
    check_bit("intr after both acks", 1'b0, intr_o);
  endtask

  initial begin
    check_cnt   = 0;
    error_cnt   = 0;
    timeout_cnt = 0;
    void'($urandom(62));
    rst_n_i   = 1'b0;
    adr_i     = '0;
    dat_i     = '0;
    we_i      = 1'b0;
    tga_i     = 1'b0;
    sel_i     = 2'b00;
    stb_i     = 1'b0;
    cyc_i     = 1'b0;
    inta_i    = 1'b0;
    ext_irq_i = 1'b0;
    repeat (10) @(posedge clk);
    @(negedge clk);
    rst_n_i = 1'b1;
    check_word("led after reset", '0, led_o);
    check_bit("intr after reset", 1'b0, intr_o);
    test_main_ram();
    test_video_page();
    test_led_io();
    test_timer_irq();
    test_ext_irq();
    test_both_irqs();
    $display("Checks: %0d, mismatches: %0d, timeouts: %0d", check_cnt, error_cnt, timeout_cnt);
    if (error_cnt == 0 && timeout_cnt == 0) begin
      $display("*** PASSED ***");
    end else begin
      $display("*** FAILED ***");
    end
    $finish;
  end

endmodule

`default_nettype wire

/* run.sh */
#!/bin/sh
# Build and run the testbench with Verilator, then look for the pass line
LOG=sim.log

rm -rf obj_dir "$LOG"

verilator --binary --timing --assert --timescale 1ns/1ns \
  --top-module soc_tb -f verilog.f > "$LOG" 2>&1 &&
  ./obj_dir/Vsoc_tb >> "$LOG" 2>&1 ||
  echo "Build or simulation exited with an error" >> "$LOG"

cat "$LOG"
grep -qxF '*** PASSED ***' "$LOG" && echo "Simulation passed" ||
  { echo "Simulation failed"; exit 1; }

/* source/bus_fabric.sv */
// Address decoder and read mux
`timescale 1ns/1ns
`default_nettype none

module bus_fabric (
  input  logic           clk,
  input  logic           rst_n_i,

  // Master side
  input  bus_pkg::adr_t  adr_i,
  input  bus_pkg::word_t dat_i,
  input  logic           we_i,
  input  logic           tga_i,
  input  bus_pkg::sel_t  sel_i,
  input  logic           stb_i,
  input  logic           cyc_i,
  input  logic           inta_i,
  output bus_pkg::word_t dat_o,
  output logic           ack_o,

  // Memory slaves
  output logic           main_stb_o,
  output logic           video_stb_o,
  input  bus_pkg::word_t main_dat_i,
  input  logic           main_ack_i,
  input  bus_pkg::word_t video_dat_i,
  input  logic           video_ack_i,

  // Interrupt controller
  input  logic           iid_i,
  output logic           inta_done_o,

  // Board LEDs
  output bus_pkg::word_t led_o
);

  import bus_pkg::*;

  logic  bus_req;
  logic  mem_cyc;
  logic  io_cyc;
  logic  video_arena;
  logic  main_arena;
  logic  led_arena;
  logic  led_wr;
  logic  mem_ack;
  word_t io_dat;
  word_t mem_dat;
  word_t led_q;

  assign bus_req = stb_i & cyc_i;

  // Interrupt acknowledge cycles never reach a slave
  assign mem_cyc = !tga_i && !inta_i;
  assign io_cyc  = tga_i && !inta_i;

  // Address map decode
  assign video_arena = mem_cyc && (adr_i[19:12] == VIDEO_PAGE);
  assign main_arena  = mem_cyc && (adr_i[19:12] != VIDEO_PAGE);
  assign led_arena   = io_cyc && (adr_i[15:8] == LED_IO_PAGE);

  // Slave strobes
  assign video_stb_o = video_arena & bus_req;
  assign main_stb_o  = main_arena & bus_req;

  // Vector fetch completes in the same cycle
  assign inta_done_o = inta_i & bus_req;

  assign led_wr = led_arena && bus_req && we_i;

  // LED register with byte lanes from sel
  always_ff @(posedge clk) begin
    if (!rst_n_i) begin
      led_q <= '0;
    end else if (led_wr) begin
      if (sel_i[0]) begin
        led_q[7:0] <= dat_i[7:0];
      end
      if (sel_i[1]) begin
        led_q[15:8] <= dat_i[15:8];
      end
    end
  end

  assign led_o = led_q;

  // Memory side of the muxes
  assign mem_ack = video_arena ? video_ack_i : main_ack_i;
  assign mem_dat = video_arena ? video_dat_i : main_dat_i;

  // Only the LED page answers with real data on I/O
  assign io_dat = led_arena ? led_q : UNMAPPED_IO_DATA;

  // I/O and inta cycles are zero wait
  always_comb begin
    if (inta_i || tga_i) begin
      ack_o = bus_req;
    end else begin
      ack_o = mem_ack;
    end
  end

  // Read data in the same priority order as ack
  always_comb begin
    if (inta_i) begin
      dat_o = IRQ_VECTOR_BASE + word_t'(iid_i);
    end else if (tga_i) begin
      dat_o = io_dat;
    end else begin
      dat_o = mem_dat;
    end
  end

endmodule

`default_nettype wire

/* source/bus_pkg.sv */
// System bus definitions
`default_nettype none

package bus_pkg;

  // Bus widths
  localparam int unsigned ADR_W = 19;
  localparam int unsigned DAT_W = 16;

  // Word address covers bits 19 to 1, byte lane is implied by sel
  typedef logic [ADR_W:1]   adr_t;
  typedef logic [DAT_W-1:0] word_t;
  typedef logic [1:0]       sel_t;

  // Address map
  localparam logic [7:0] VIDEO_PAGE  = 8'hB8;
  localparam logic [7:0] LED_IO_PAGE = 8'hF1;

  // RAM geometry and latency
  localparam int unsigned MAIN_RAM_AW  = 12;
  localparam int unsigned VIDEO_RAM_AW = 11;
  localparam int unsigned MAIN_WAIT    = 2;
  localparam int unsigned VIDEO_WAIT   = 0;

  // Clock cycles between timer requests
  localparam int unsigned TIMER_PERIOD = 200;

  // Interrupt lines, 0 is the timer and wins over 1 (external)
  localparam int unsigned NUM_IRQ = 2;

  typedef logic [NUM_IRQ-1:0] irq_t;

  // Vector word is base plus line id
  localparam word_t IRQ_VECTOR_BASE = 16'h0008;

  // Reads from nowhere on the I/O side
  localparam word_t UNMAPPED_IO_DATA = 16'hFFFF;

endpackage

`default_nettype wire

/* source/interval_timer.sv */
// Periodic interrupt timer
`timescale 1ns/1ns
`default_nettype none

module interval_timer (
  input  logic clk,
  input  logic rst_n_i,
  output logic irq_o
);

  import bus_pkg::*;

  localparam int unsigned CNT_W = $clog2(TIMER_PERIOD);

  logic [CNT_W-1:0] tick_cnt;
  logic             wrap;

  assign wrap = (tick_cnt == CNT_W'(TIMER_PERIOD - 1));

  // Free-running count, one request pulse per wrap
  always_ff @(posedge clk) begin
    if (!rst_n_i) begin
      tick_cnt <= '0;
      irq_o    <= 1'b0;
    end else begin
      irq_o <= wrap;
      if (wrap) begin
        tick_cnt <= '0;
      end else begin
        tick_cnt <= tick_cnt + 1'b1;
      end
    end
  end

endmodule

`default_nettype wire

/* source/priority_pic.sv */
// Fixed priority interrupt controller
`timescale 1ns/1ns
`default_nettype none

module priority_pic (
  input  logic          clk,
  input  logic          rst_n_i,
  input  bus_pkg::irq_t irq_i,
  input  logic          ack_i,
  output logic          intr_o,
  output logic          iid_o
);

  import bus_pkg::*;

  irq_t irq_q;
  irq_t pending_q;
  irq_t rise;
  irq_t clr;

  // Only a new request counts, a held line does not re-arm
  assign rise = irq_i & ~irq_q;

  // Lowest pending line wins
  always_comb begin
    iid_o = 1'b0;
    for (int i = NUM_IRQ - 1; i >= 0; i--) begin
      if (pending_q[i]) begin
        iid_o = 1'(i);
      end
    end
  end

  // Drop the line being acknowledged
  always_comb begin
    clr = '0;
    if (ack_i) begin
      clr[iid_o] = 1'b1;
    end
  end

  always_ff @(posedge clk) begin
    if (!rst_n_i) begin
      irq_q     <= '0;
      pending_q <= '0;
    end else begin
      irq_q     <= irq_i;
      pending_q <= (pending_q & ~clr) | rise;
    end
  end

  assign intr_o = |pending_q;

endmodule

`default_nettype wire

/* source/soc_top.sv */
// Board system bus top
`timescale 1ns/1ns
`default_nettype none

module soc_top (
  input  logic           clk,
  input  logic           rst_n_i,

  // CPU bus
  input  bus_pkg::adr_t  adr_i,
  input  bus_pkg::word_t dat_i,
  input  logic           we_i,
  input  logic           tga_i,
  input  bus_pkg::sel_t  sel_i,
  input  logic           stb_i,
  input  logic           cyc_i,
  input  logic           inta_i,
  output bus_pkg::word_t dat_o,
  output logic           ack_o,

  input  logic           ext_irq_i,
  output logic           intr_o,
  output bus_pkg::word_t led_o
);

  import bus_pkg::*;

  logic  main_stb;
  logic  main_ack;
  word_t main_dat;
  logic  video_stb;
  logic  video_ack;
  word_t video_dat;
  logic  timer_irq;
  logic  iid;
  logic  inta_done;

  bus_fabric i_bus_fabric (
    .clk         (clk),
    .rst_n_i     (rst_n_i),
    .adr_i       (adr_i),
    .dat_i       (dat_i),
    .we_i        (we_i),
    .tga_i       (tga_i),
    .sel_i       (sel_i),
    .stb_i       (stb_i),
    .cyc_i       (cyc_i),
    .inta_i      (inta_i),
    .dat_o       (dat_o),
    .ack_o       (ack_o),
    .main_stb_o  (main_stb),
    .video_stb_o (video_stb),
    .main_dat_i  (main_dat),
    .main_ack_i  (main_ack),
    .video_dat_i (video_dat),
    .video_ack_i (video_ack),
    .iid_i       (iid),
    .inta_done_o (inta_done),
    .led_o       (led_o)
  );

  // Main RAM aliases over the whole memory space
  wait_state_ram #(
    .AW   (MAIN_RAM_AW),
    .WAIT (MAIN_WAIT)
  ) i_main_ram (
    .clk     (clk),
    .rst_n_i (rst_n_i),
    .stb_i   (main_stb),
    .we_i    (we_i),
    .adr_i   (adr_i[MAIN_RAM_AW:1]),
    .sel_i   (sel_i),
    .dat_i   (dat_i),
    .dat_o   (main_dat),
    .ack_o   (main_ack)
  );

  // Text buffer at B8000
  wait_state_ram #(
    .AW   (VIDEO_RAM_AW),
    .WAIT (VIDEO_WAIT)
  ) i_video_ram (
    .clk     (clk),
    .rst_n_i (rst_n_i),
    .stb_i   (video_stb),
    .we_i    (we_i),
    .adr_i   (adr_i[VIDEO_RAM_AW:1]),
    .sel_i   (sel_i),
    .dat_i   (dat_i),
    .dat_o   (video_dat),
    .ack_o   (video_ack)
  );

  interval_timer i_interval_timer (
    .clk     (clk),
    .rst_n_i (rst_n_i),
    .irq_o   (timer_irq)
  );

  // Timer on line 0, external on line 1
  priority_pic i_priority_pic (
    .clk     (clk),
    .rst_n_i (rst_n_i),
    .irq_i   ({ext_irq_i, timer_irq}),
    .ack_i   (inta_done),
    .intr_o  (intr_o),
    .iid_o   (iid)
  );

endmodule

`default_nettype wire

/* source/wait_state_ram.sv */
// Word RAM with wait states
`timescale 1ns/1ns
`default_nettype none

module wait_state_ram #(
  parameter int unsigned AW   = 12,
  parameter int unsigned WAIT = 0
) (
  input  logic           clk,
  input  logic           rst_n_i,
  input  logic           stb_i,
  input  logic           we_i,
  input  logic [AW-1:0]  adr_i,
  input  bus_pkg::sel_t  sel_i,
  input  bus_pkg::word_t dat_i,
  output bus_pkg::word_t dat_o,
  output logic           ack_o
);

  import bus_pkg::*;

  // Wide enough to hold WAIT, and never zero bits wide
  localparam int unsigned CNT_W = $clog2(WAIT + 2);

  word_t            mem [2**AW];
  logic [CNT_W-1:0] wait_cnt;
  logic             done_q;
  logic             fire;

  // Request still open and the last wait state is reached
  assign fire = stb_i && !done_q && (wait_cnt == CNT_W'(WAIT));

  // Wait counter and ack pulse
  always_ff @(posedge clk) begin
    if (!rst_n_i) begin
      wait_cnt <= '0;
      done_q   <= 1'b0;
      ack_o    <= 1'b0;
    end else if (!stb_i) begin
      // Master released the strobe, get ready for the next cycle
      wait_cnt <= '0;
      done_q   <= 1'b0;
      ack_o    <= 1'b0;
    end else if (done_q) begin
      // Acked already, hold off until stb drops
      ack_o <= 1'b0;
    end else if (fire) begin
      ack_o  <= 1'b1;
      done_q <= 1'b1;
    end else begin
      wait_cnt <= wait_cnt + 1'b1;
    end
  end

  // Storage, written with the byte lanes at the acking edge
  always_ff @(posedge clk) begin
    if (fire && we_i) begin
      if (sel_i[0]) begin
        mem[adr_i][7:0] <= dat_i[7:0];
      end
      if (sel_i[1]) begin
        mem[adr_i][15:8] <= dat_i[15:8];
      end
    end
  end

  // Read word lines up with ack
  always_ff @(posedge clk) begin
    if (fire) begin
      dat_o <= mem[adr_i];
    end
  end

endmodule

`default_nettype wire

/* verilog.f */
source/bus_pkg.sv
source/wait_state_ram.sv
source/interval_timer.sv
source/priority_pic.sv
source/bus_fabric.sv
source/soc_top.sv
dv/soc_properties.sv
dv/soc_tb.sv
